// File: axi_rd_sub.f
axi_rd_proto_pkg.sv
rd_sub_cfg_pkg.sv
burst_addr_gen.sv
ar_burst_ctrl.sv
req_ctx_delay.sv
rd_skid_buffer.sv
axi_rd_sub.sv
tb_axi_rd_sub.sv

// File: axi_rd_sub_golden.txt
// AXI read subordinate tests in hex; first word is the number of tests
// Each test: id burst size len addr err_lo err_hi, then len+1 beats {resp, last, 0, rdata}
5
// INCR, 8 beats, empty error window
3 1 2 07 00001000 ffffffff 00000000
05a5a1000 05a5a1004 05a5a1008 05a5a100c 05a5a1010 05a5a1014 05a5a1018 25a5a101c
// WRAP, 4 beats starting mid 16-byte window
5 2 2 03 00002008 ffffffff 00000000
05a5a2008 05a5a200c 05a5a2000 25a5a2004
// FIXED, 4 beats on one word
9 0 2 03 00003004 ffffffff 00000000
05a5a3004 05a5a3004 05a5a3004 25a5a3004
// INCR, 6 beats crossing an error window of two words
c 1 2 05 00004000 00004008 0000400c
05a5a4000 05a5a4004 85a5a4008 85a5a400c 05a5a4010 25a5a4014
// INCR, single beat inside the error window
1 1 2 00 00005010 00005010 00005010
a5a5a5010

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
# Exit status is nonzero unless the log holds the pass line

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_axi_rd_sub -f axi_rd_sub.f -o tb_axi_rd_sub \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/tb_axi_rd_sub > sim.log 2>&1 \
    || echo "simulator returned an error status"

cat sim.log

grep -qx "TB PASSED" sim.log \
    && { echo "result: pass"; exit 0; } \
    || { echo "result: fail"; exit 1; }

// File: tb_axi_rd_sub.sv
// ------------------------------
// Testbench for the AXI4 read subordinate
// Tests and expected beats come from axi_rd_sub_golden.txt
// Must run from the project root to find that file
// Component model answers COMP_LAT cycles after each accept
// ------------------------------
`timescale 1ns/1ps

module tb_axi_rd_sub;

    localparam int MAX_TESTS = 8;
    localparam int MAX_WORDS = 256;
    localparam int LAT       = rd_sub_cfg_pkg::COMP_LAT;
    // Phase one runs each test alone, phase two runs them twice back to back
    localparam int ROUNDS    = 3;

    logic                                    clk;
    logic                                    rst_n     = 1'b0;
    logic                                    i_arvalid = 1'b0;
    logic                                    o_arready;
    logic [axi_rd_proto_pkg::AXI_AW-1:0]     i_araddr  = '0;
    logic [axi_rd_proto_pkg::AXI_LEN_W-1:0]  i_arlen   = '0;
    logic [axi_rd_proto_pkg::AXI_SIZE_W-1:0] i_arsize  = '0;
    axi_rd_proto_pkg::axi_burst_e            i_arburst = axi_rd_proto_pkg::BURST_INCR;
    logic [axi_rd_proto_pkg::AXI_IW-1:0]     i_arid    = '0;
    logic                                    o_rvalid;
    logic                                    i_rready  = 1'b1;
    logic [axi_rd_proto_pkg::AXI_DW-1:0]     o_rdata;
    logic [axi_rd_proto_pkg::AXI_IW-1:0]     o_rid;
    axi_rd_proto_pkg::axi_resp_e             o_rresp;
    logic                                    o_rlast;
    logic                                    o_req;
    logic [axi_rd_proto_pkg::AXI_AW-1:0]     o_req_addr;
    logic [axi_rd_proto_pkg::AXI_SIZE_W-1:0] o_req_size;
    logic                                    o_req_last;
    logic                                    i_hld     = 1'b0;
    logic [axi_rd_proto_pkg::AXI_DW-1:0]     i_rdata;
    logic                                    i_err;

    // Component answer pipe, oldest entry at LAT-1
    logic [LAT-1:0][axi_rd_proto_pkg::AXI_DW-1:0] comp_data = '0;
    logic [LAT-1:0]                               comp_err  = '0;
    int                                           req_burst = 0;

    // Test table from the golden file
    logic [35:0] gold [MAX_WORDS];
    int          n_tests = 1;
    logic [3:0]  t_id    [MAX_TESTS];
    logic [1:0]  t_burst [MAX_TESTS];
    logic [2:0]  t_size  [MAX_TESTS];
    logic [7:0]  t_len   [MAX_TESTS];
    logic [31:0] t_addr  [MAX_TESTS];
    logic [31:0] t_elo   [MAX_TESTS];
    logic [31:0] t_ehi   [MAX_TESTS];
    int          t_base  [MAX_TESTS];
    int          total_beats = 0;

    // Expected R beats {resp, last, 0, data} and their IDs
    logic [35:0] exp_q    [$];
    logic [3:0]  exp_id_q [$];

    int errors       = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    bit stall_en     = 1'b0;
    bit loaded       = 1'b0;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    axi_rd_sub dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_arvalid  (i_arvalid),
        .o_arready  (o_arready),
        .i_araddr   (i_araddr),
        .i_arlen    (i_arlen),
        .i_arsize   (i_arsize),
        .i_arburst  (i_arburst),
        .i_arid     (i_arid),
        .o_rvalid   (o_rvalid),
        .i_rready   (i_rready),
        .o_rdata    (o_rdata),
        .o_rid      (o_rid),
        .o_rresp    (o_rresp),
        .o_rlast    (o_rlast),
        .o_req      (o_req),
        .o_req_addr (o_req_addr),
        .o_req_size (o_req_size),
        .o_req_last (o_req_last),
        .i_hld      (i_hld),
        .i_rdata    (i_rdata),
        .i_err      (i_err)
    );

    // Error window is inclusive on both ends, lo above hi means none
    function automatic logic in_window(input logic [31:0] a, input int t);
        return (a >= t_elo[t]) && (a <= t_ehi[t]);
    endfunction

    // Expected beat n of test t from the AXI address rules
    function automatic logic [35:0] rule_beat(input int t, input int n);
        logic [31:0] nbytes;
        logic [31:0] total;
        logic [31:0] lower;
        logic [31:0] a;
        logic [1:0]  resp;
        nbytes = 32'd1 << t_size[t];
        a      = t_addr[t];
        if (t_burst[t] != axi_rd_proto_pkg::BURST_FIXED && n != 0) begin
            a = (t_addr[t] / nbytes) * nbytes + n * nbytes;
            if (t_burst[t] == axi_rd_proto_pkg::BURST_WRAP) begin
                total = nbytes * (t_len[t] + 1);
                lower = (t_addr[t] / total) * total;
                // Past the window top, fold back to its base
                if (a >= lower + total) begin
                    a = a - total;
                end
            end
        end
        a    = a & ~32'h3;
        resp = in_window(a, t) ? axi_rd_proto_pkg::RESP_SLVERR : axi_rd_proto_pkg::RESP_OKAY;
        return {resp, (n == int'(t_len[t])), 1'b0, a ^ 32'h5a5a_0000};
    endfunction

    // ------------------------------
    // Component model and stalls
    // ------------------------------
    always @(posedge clk) begin
        if (o_req && !i_hld) begin
            // Request size follows ARSIZE of the burst being served
            if (o_req_size !== t_size[req_burst % n_tests]) begin
                $display("ERROR t=%0t o_req_size got %h expected %h",
                         $time, o_req_size, t_size[req_burst % n_tests]);
                errors++;
            end
            comp_data[0] <= o_req_addr ^ 32'h5a5a_0000;
            comp_err[0]  <= in_window(o_req_addr, req_burst % n_tests);
            if (o_req_last) begin
                req_burst <= req_burst + 1;
            end
        end else begin
            comp_data[0] <= '0;
            comp_err[0]  <= 1'b0;
        end
        for (int k = 1; k < LAT; k++) begin
            comp_data[k] <= comp_data[k-1];
            comp_err[k]  <= comp_err[k-1];
        end
    end

    assign i_rdata = comp_data[LAT-1];
    assign i_err   = comp_err[LAT-1];

    always @(posedge clk) begin
        if (stall_en) begin
            i_rready <= ($urandom % 3) != 0;
            i_hld    <= ($urandom % 4) == 0;
        end else begin
            i_rready <= 1'b1;
            i_hld    <= 1'b0;
        end
    end

    // ------------------------------
    // R channel monitor
    // ------------------------------
    always @(posedge clk) begin
        logic [35:0] exp_beat;
        logic [3:0]  exp_id;
        if (rst_n && o_rvalid && i_rready) begin
            if (exp_q.size() == 0) begin
                $display("ERROR t=%0t R beat arrived with no burst outstanding", $time);
                errors++;
            end else begin
                exp_beat = exp_q.pop_front();
                exp_id   = exp_id_q.pop_front();
                if (o_rdata !== exp_beat[31:0]) begin
                    $display("ERROR t=%0t o_rdata got %h expected %h",
                             $time, o_rdata, exp_beat[31:0]);
                    errors++;
                end
                if (o_rid !== exp_id) begin
                    $display("ERROR t=%0t o_rid got %h expected %h", $time, o_rid, exp_id);
                    errors++;
                end
                if (o_rresp !== exp_beat[35:34]) begin
                    $display("ERROR t=%0t o_rresp got %h expected %h",
                             $time, o_rresp, exp_beat[35:34]);
                    errors++;
                end
                if (o_rlast !== exp_beat[33]) begin
                    $display("ERROR t=%0t o_rlast got %b expected %b",
                             $time, o_rlast, exp_beat[33]);
                    errors++;
                end
            end
        end
    end

    // ------------------------------
    // Test tasks
    // ------------------------------
    task automatic load_golden();
        int p;
        $readmemh("axi_rd_sub_golden.txt", gold);
        n_tests = int'(gold[0]);
        if (n_tests <= 0 || n_tests > MAX_TESTS) begin
            $display("Golden file is missing or holds a bad test count");
            errors++;
            n_tests = 1;
        end else begin
            p = 1;
            for (int t = 0; t < n_tests; t++) begin
                t_id[t]    = gold[p][3:0];
                t_burst[t] = gold[p+1][1:0];
                t_size[t]  = gold[p+2][2:0];
                t_len[t]   = gold[p+3][7:0];
                t_addr[t]  = gold[p+4][31:0];
                t_elo[t]   = gold[p+5][31:0];
                t_ehi[t]   = gold[p+6][31:0];
                t_base[t]  = p + 7;
                p          = p + 8 + int'(t_len[t]);
                total_beats += int'(t_len[t]) + 1;
                // Golden beats must agree with the address and response rules
                for (int n = 0; n <= int'(t_len[t]); n++) begin
                    if (gold[t_base[t]+n] !== rule_beat(t, n)) begin
                        $display("ERROR t=%0t golden beat %0d of test %0d got %h expected %h",
                                 $time, n, t, gold[t_base[t]+n], rule_beat(t, n));
                        errors++;
                    end
                end
            end
        end
    endtask

    // Drive one AR burst and queue its beats at the handshake
    task automatic send_ar(input int t);
        i_arvalid <= 1'b1;
        i_araddr  <= t_addr[t];
        i_arlen   <= t_len[t];
        i_arsize  <= t_size[t];
        i_arburst <= axi_rd_proto_pkg::axi_burst_e'(t_burst[t]);
        i_arid    <= t_id[t];
        @(posedge clk);
        while (!o_arready) begin
            @(posedge clk);
        end
        for (int n = 0; n <= int'(t_len[t]); n++) begin
            exp_q.push_back(gold[t_base[t]+n]);
            exp_id_q.push_back(t_id[t]);
        end
    endtask

    // Wait for every queued beat, then a few idle cycles for strays
    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (LAT + 4) @(posedge clk);
    endtask

    task automatic finish_test(input string name, input int err_mark);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_mark);
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        int err_mark;
        void'($urandom(32'h954c_e7fb));
        load_golden();
        finish_test("golden file", 0);
        loaded = 1'b1;

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // arready stays low one cycle after release
        err_mark = errors;
        @(posedge clk);
        if (o_arready !== 1'b0) begin
            $display("ERROR t=%0t o_arready got %b expected %b", $time, o_arready, 1'b0);
            errors++;
        end
        if (o_rvalid !== 1'b0) begin
            $display("ERROR t=%0t o_rvalid got %b expected %b", $time, o_rvalid, 1'b0);
            errors++;
        end
        if (o_req !== 1'b0) begin
            $display("ERROR t=%0t o_req got %b expected %b", $time, o_req, 1'b0);
            errors++;
        end
        @(posedge clk);
        if (o_arready !== 1'b1) begin
            $display("ERROR t=%0t o_arready got %b expected %b", $time, o_arready, 1'b1);
            errors++;
        end
        finish_test("reset", err_mark);

        // One burst at a time, no stalls
        for (int t = 0; t < n_tests; t++) begin
            err_mark = errors;
            send_ar(t);
            i_arvalid <= 1'b0;
            drain();
            finish_test($sformatf("single burst %0d", t), err_mark);
        end

        // All bursts back to back with random rready and hld
        err_mark = errors;
        stall_en <= 1'b1;
        for (int r = 0; r < ROUNDS - 1; r++) begin
            for (int t = 0; t < n_tests; t++) begin
                send_ar(t);
            end
        end
        i_arvalid <= 1'b0;
        drain();
        stall_en <= 1'b0;
        finish_test("back to back with stalls", err_mark);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog sized from the beat count of all rounds
    initial begin
        wait (loaded);
        repeat (ROUNDS * total_beats * 40 + 200) @(posedge clk);
        $display("Watchdog expired, the run did not finish in time");
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: axi_rd_sub.sv
// ------------------------------
// AXI4 read subordinate, top level
// No exclusive access and no user sideband
// R beats return in request order regardless of ID
// Component latency fixed at rd_sub_cfg_pkg::COMP_LAT
// ------------------------------
`timescale 1ns/1ps

module axi_rd_sub (
    input  logic                                    clk,
    input  logic                                    rst_n,
    // AR channel
    input  logic                                    i_arvalid,
    output logic                                    o_arready,
    input  logic [axi_rd_proto_pkg::AXI_AW-1:0]     i_araddr,
    input  logic [axi_rd_proto_pkg::AXI_LEN_W-1:0]  i_arlen,
    input  logic [axi_rd_proto_pkg::AXI_SIZE_W-1:0] i_arsize,
    input  axi_rd_proto_pkg::axi_burst_e            i_arburst,
    input  logic [axi_rd_proto_pkg::AXI_IW-1:0]     i_arid,
    // R channel
    output logic                                    o_rvalid,
    input  logic                                    i_rready,
    output logic [axi_rd_proto_pkg::AXI_DW-1:0]     o_rdata,
    output logic [axi_rd_proto_pkg::AXI_IW-1:0]     o_rid,
    output axi_rd_proto_pkg::axi_resp_e             o_rresp,
    output logic                                    o_rlast,
    // Component
    output logic                                    o_req,
    output logic [axi_rd_proto_pkg::AXI_AW-1:0]     o_req_addr,
    output logic [axi_rd_proto_pkg::AXI_SIZE_W-1:0] o_req_size,
    output logic                                    o_req_last,
    input  logic                                    i_hld,
    input  logic [axi_rd_proto_pkg::AXI_DW-1:0]     i_rdata,
    input  logic                                    i_err
);

    logic                                room;
    logic                                issue;
    logic [axi_rd_proto_pkg::AXI_IW-1:0] issue_id;

    // Skid chain nets, index 0 is the chain input
    logic [rd_sub_cfg_pkg::SKID_STAGES:0] sk_valid;
    logic [rd_sub_cfg_pkg::SKID_STAGES:0] sk_ready;
    logic [axi_rd_proto_pkg::AXI_DW-1:0]  sk_data [rd_sub_cfg_pkg::SKID_STAGES+1];
    logic [axi_rd_proto_pkg::AXI_IW-1:0]  sk_id   [rd_sub_cfg_pkg::SKID_STAGES+1];
    axi_rd_proto_pkg::axi_resp_e          sk_resp [rd_sub_cfg_pkg::SKID_STAGES+1];
    logic                                 sk_last [rd_sub_cfg_pkg::SKID_STAGES+1];

    ar_burst_ctrl ctrl_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_arvalid  (i_arvalid),
        .o_arready  (o_arready),
        .i_araddr   (i_araddr),
        .i_arlen    (i_arlen),
        .i_arsize   (i_arsize),
        .i_arburst  (i_arburst),
        .i_arid     (i_arid),
        .i_room     (room),
        .i_hld      (i_hld),
        .o_req      (o_req),
        .o_req_addr (o_req_addr),
        .o_req_size (o_req_size),
        .o_req_last (o_req_last),
        .o_issue    (issue),
        .o_issue_id (issue_id)
    );

    // Context lines up with i_rdata after the component latency
    req_ctx_delay #(
        .DEPTH (rd_sub_cfg_pkg::COMP_LAT)
    ) ctx_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_valid (issue),
        .i_id    (issue_id),
        .i_last  (o_req_last),
        .o_valid (sk_valid[0]),
        .o_id    (sk_id[0]),
        .o_last  (sk_last[0])
    );

    // ------------------------------
    // Response and skid chain
    // ------------------------------
    assign sk_data[0] = i_rdata;
    assign sk_resp[0] = i_err ? axi_rd_proto_pkg::RESP_SLVERR : axi_rd_proto_pkg::RESP_OKAY;

    generate
        for (genvar g = 0; g < rd_sub_cfg_pkg::SKID_STAGES; g++) begin : g_skid
            rd_skid_buffer skid_i (
                .clk     (clk),
                .rst_n   (rst_n),
                .i_valid (sk_valid[g]),
                .o_ready (sk_ready[g]),
                .i_data  (sk_data[g]),
                .i_id    (sk_id[g]),
                .i_resp  (sk_resp[g]),
                .i_last  (sk_last[g]),
                .o_valid (sk_valid[g+1]),
                .i_ready (sk_ready[g+1]),
                .o_data  (sk_data[g+1]),
                .o_id    (sk_id[g+1]),
                .o_resp  (sk_resp[g+1]),
                .o_last  (sk_last[g+1])
            );
        end
    endgenerate

    // Issue only while every stage has a free skid slot
    // so all beats in flight find a place under a full stall
    assign room = &sk_ready[rd_sub_cfg_pkg::SKID_STAGES-1:0];

    // Last stage faces the master
    assign sk_ready[rd_sub_cfg_pkg::SKID_STAGES] = i_rready;
    assign o_rvalid = sk_valid[rd_sub_cfg_pkg::SKID_STAGES];
    assign o_rdata  = sk_data[rd_sub_cfg_pkg::SKID_STAGES];
    assign o_rid    = sk_id[rd_sub_cfg_pkg::SKID_STAGES];
    assign o_rresp  = sk_resp[rd_sub_cfg_pkg::SKID_STAGES];
    assign o_rlast  = sk_last[rd_sub_cfg_pkg::SKID_STAGES];

    // Component answers cannot be stalled, so a refused beat is lost
    no_drop_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(sk_valid[0] && !sk_ready[0]));

endmodule

// File: rd_skid_buffer.sv
// ------------------------------
// Skid stage for one R beat
// Empty stage is a zero-cycle path
// o_ready is registered and falls a cycle after a stall
// ------------------------------
`timescale 1ns/1ps

module rd_skid_buffer (
    input  logic                                clk,
    input  logic                                rst_n,
    // Upstream
    input  logic                                i_valid,
    output logic                                o_ready,
    input  logic [axi_rd_proto_pkg::AXI_DW-1:0] i_data,
    input  logic [axi_rd_proto_pkg::AXI_IW-1:0] i_id,
    input  axi_rd_proto_pkg::axi_resp_e         i_resp,
    input  logic                                i_last,
    // Downstream
    output logic                                o_valid,
    input  logic                                i_ready,
    output logic [axi_rd_proto_pkg::AXI_DW-1:0] o_data,
    output logic [axi_rd_proto_pkg::AXI_IW-1:0] o_id,
    output axi_rd_proto_pkg::axi_resp_e         o_resp,
    output logic                                o_last
);

    logic                                skid_valid;
    logic [axi_rd_proto_pkg::AXI_DW-1:0] skid_data;
    logic [axi_rd_proto_pkg::AXI_IW-1:0] skid_id;
    axi_rd_proto_pkg::axi_resp_e         skid_resp;
    logic                                skid_last;

    // Ready only while the skid register is free
    assign o_ready = !skid_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            skid_valid <= 1'b0;
        end else if (skid_valid) begin
            // Drain once downstream takes it
            if (i_ready) begin
                skid_valid <= 1'b0;
            end
        end else if (i_valid && !i_ready) begin
            skid_valid <= 1'b1;
        end
    end

    // Capture the passing beat when downstream stalls
    always_ff @(posedge clk) begin
        if (!skid_valid && i_valid && !i_ready) begin
            skid_data <= i_data;
            skid_id   <= i_id;
            skid_resp <= i_resp;
            skid_last <= i_last;
        end
    end

    // ------------------------------
    // Output mux
    // ------------------------------
    assign o_valid = skid_valid || i_valid;
    assign o_data  = skid_valid ? skid_data : i_data;
    assign o_id    = skid_valid ? skid_id   : i_id;
    assign o_resp  = skid_valid ? skid_resp : i_resp;
    assign o_last  = skid_valid ? skid_last : i_last;

    // A stalled beat stays put until taken
    stall_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        (o_valid && !i_ready) |=>
            (o_valid && $stable(o_data) && $stable(o_id) && $stable(o_resp) && $stable(o_last)));

endmodule

// File: req_ctx_delay.sv
// ------------------------------
// Carries valid, ID and last beside each request
// Delay is DEPTH cycles, DEPTH of zero gives wires
// Only the valid bits are reset
// ------------------------------
`timescale 1ns/1ps

module req_ctx_delay #(
    parameter int DEPTH = rd_sub_cfg_pkg::COMP_LAT
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                i_valid,
    input  logic [axi_rd_proto_pkg::AXI_IW-1:0] i_id,
    input  logic                                i_last,
    output logic                                o_valid,
    output logic [axi_rd_proto_pkg::AXI_IW-1:0] o_id,
    output logic                                o_last
);

    generate
        if (DEPTH == 0) begin : g_wire
            // Component answers in the request cycle
            assign o_valid = i_valid;
            assign o_id    = i_id;
            assign o_last  = i_last;
        end else begin : g_shift
            logic                                valid_q [DEPTH];
            logic [axi_rd_proto_pkg::AXI_IW-1:0] id_q    [DEPTH];
            logic                                last_q  [DEPTH];

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int i = 0; i < DEPTH; i++) begin
                        valid_q[i] <= 1'b0;
                    end
                end else begin
                    valid_q[0] <= i_valid;
                    for (int i = 1; i < DEPTH; i++) begin
                        valid_q[i] <= valid_q[i-1];
                    end
                end
            end

            // Payload just follows, valid qualifies it
            always_ff @(posedge clk) begin
                id_q[0]   <= i_id;
                last_q[0] <= i_last;
                for (int i = 1; i < DEPTH; i++) begin
                    id_q[i]   <= id_q[i-1];
                    last_q[i] <= last_q[i-1];
                end
            end

            assign o_valid = valid_q[DEPTH-1];
            assign o_id    = id_q[DEPTH-1];
            assign o_last  = last_q[DEPTH-1];
        end
    endgenerate

endmodule

// File: ar_burst_ctrl.sv
// ------------------------------
// AR channel intake and component request issue
// One burst at a time, next AR taken on its final accept
// Requests wait for i_room so no answer can be dropped
// ------------------------------
`timescale 1ns/1ps

module ar_burst_ctrl (
    input  logic                                    clk,
    input  logic                                    rst_n,
    // AR channel
    input  logic                                    i_arvalid,
    output logic                                    o_arready,
    input  logic [axi_rd_proto_pkg::AXI_AW-1:0]     i_araddr,
    input  logic [axi_rd_proto_pkg::AXI_LEN_W-1:0]  i_arlen,
    input  logic [axi_rd_proto_pkg::AXI_SIZE_W-1:0] i_arsize,
    input  axi_rd_proto_pkg::axi_burst_e            i_arburst,
    input  logic [axi_rd_proto_pkg::AXI_IW-1:0]     i_arid,
    // Space left in the skid chain
    input  logic                                    i_room,
    // Component request side
    input  logic                                    i_hld,
    output logic                                    o_req,
    output logic [axi_rd_proto_pkg::AXI_AW-1:0]     o_req_addr,
    output logic [axi_rd_proto_pkg::AXI_SIZE_W-1:0] o_req_size,
    output logic                                    o_req_last,
    // Strobe into the context delay line
    output logic                                    o_issue,
    output logic [axi_rd_proto_pkg::AXI_IW-1:0]     o_issue_id
);

    logic out_of_rst;
    logic active;
    logic ar_take;
    logic accept;
    logic final_accept;

    // Burst context
    logic [axi_rd_proto_pkg::AXI_AW-1:0]     addr_q;
    logic [axi_rd_proto_pkg::AXI_SIZE_W-1:0] size_q;
    axi_rd_proto_pkg::axi_burst_e            burst_q;
    logic [axi_rd_proto_pkg::AXI_LEN_W-1:0]  len_q;
    logic [axi_rd_proto_pkg::AXI_IW-1:0]     id_q;
    // Beats left after the current one
    logic [axi_rd_proto_pkg::AXI_LEN_W-1:0]  cnt_q;
    logic [axi_rd_proto_pkg::AXI_AW-1:0]     next_addr;

    // ------------------------------
    // Handshakes
    // ------------------------------
    assign accept       = o_req && !i_hld;
    assign final_accept = accept && o_req_last;
    // Held low for one cycle after reset release
    assign o_arready    = out_of_rst && (!active || final_accept);
    assign ar_take      = i_arvalid && o_arready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_of_rst <= 1'b0;
            active     <= 1'b0;
            cnt_q      <= '0;
        end else begin
            out_of_rst <= 1'b1;
            if (ar_take) begin
                // New burst wins over the final accept of the old one
                active <= 1'b1;
                cnt_q  <= i_arlen;
            end else if (accept) begin
                if (final_accept) begin
                    active <= 1'b0;
                end else begin
                    cnt_q <= cnt_q - 1'b1;
                end
            end
        end
    end

    // Context loads on AR, address steps on each accept
    always_ff @(posedge clk) begin
        if (ar_take) begin
            addr_q  <= i_araddr;
            size_q  <= i_arsize;
            burst_q <= i_arburst;
            len_q   <= i_arlen;
            id_q    <= i_arid;
        end else if (accept) begin
            addr_q  <= next_addr;
        end
    end

    burst_addr_gen addr_gen_i (
        .i_addr      (addr_q),
        .i_size      (size_q),
        .i_burst     (burst_q),
        .i_len       (len_q),
        .o_next_addr (next_addr)
    );

    // ------------------------------
    // Component request
    // ------------------------------
    assign o_req      = active && i_room;
    // Component sees whole words only
    assign o_req_addr = {addr_q[axi_rd_proto_pkg::AXI_AW-1:rd_sub_cfg_pkg::BYTE_W],
                         {rd_sub_cfg_pkg::BYTE_W{1'b0}}};
    assign o_req_size = size_q;
    assign o_req_last = (cnt_q == '0);
    assign o_issue    = accept;
    assign o_issue_id = id_q;

    // Master must not withdraw a pending burst
    ar_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        (i_arvalid && !o_arready) |=> i_arvalid);

endmodule

// File: burst_addr_gen.sv
// ------------------------------
// Next beat address of an AXI read burst
// WRAP needs len of 1, 3, 7 or 15 and a size-aligned start
// Purely combinational
// ------------------------------
`timescale 1ns/1ps

module burst_addr_gen (
    input  logic [axi_rd_proto_pkg::AXI_AW-1:0]     i_addr,
    input  logic [axi_rd_proto_pkg::AXI_SIZE_W-1:0] i_size,
    input  axi_rd_proto_pkg::axi_burst_e            i_burst,
    input  logic [axi_rd_proto_pkg::AXI_LEN_W-1:0]  i_len,
    output logic [axi_rd_proto_pkg::AXI_AW-1:0]     o_next_addr
);

    // Bytes per beat
    logic [axi_rd_proto_pkg::AXI_AW-1:0] size_bytes;
    // Length zero-extended to address width
    logic [axi_rd_proto_pkg::AXI_AW-1:0] len_ext;
    // Current address rounded down to the beat size
    logic [axi_rd_proto_pkg::AXI_AW-1:0] aligned_addr;
    logic [axi_rd_proto_pkg::AXI_AW-1:0] incr_addr;
    // Low bits that stay inside the wrap window
    logic [axi_rd_proto_pkg::AXI_AW-1:0] wrap_mask;

    always_comb begin
        size_bytes   = {{(axi_rd_proto_pkg::AXI_AW-1){1'b0}}, 1'b1} << i_size;
        len_ext      = {{(axi_rd_proto_pkg::AXI_AW-axi_rd_proto_pkg::AXI_LEN_W){1'b0}}, i_len};
        aligned_addr = i_addr & ~(size_bytes - 1'b1);
        // An unaligned first beat snaps to the next size boundary
        incr_addr    = aligned_addr + size_bytes;
        // Window is (len+1) beats of size bytes
        wrap_mask    = ((len_ext + 1'b1) << i_size) - 1'b1;
    end

    always_comb begin
        case (i_burst)
            axi_rd_proto_pkg::BURST_FIXED: begin
                o_next_addr = i_addr;
            end
            axi_rd_proto_pkg::BURST_WRAP: begin
                // Keep window base, wrap the offset
                o_next_addr = (i_addr & ~wrap_mask) | (incr_addr & wrap_mask);
            end
            default: begin
                // INCR, reserved type treated the same
                o_next_addr = incr_addr;
            end
        endcase
    end

endmodule

// File: rd_sub_cfg_pkg.sv
// ------------------------------
// Implementation constants of the read subordinate
// COMP_LAT must match the attached component
// BYTE_W must equal log2 of data bytes
// ------------------------------
package rd_sub_cfg_pkg;

    // Cycles from request accept to valid read data
    localparam int COMP_LAT = 2;

    // One skid stage per in-flight answer plus one
    // for the beat already sitting on the R channel
    localparam int SKID_STAGES = COMP_LAT + 1;

    // Byte offset bits inside one data word
    localparam int BYTE_W = 2;

endpackage

// File: axi_rd_proto_pkg.sv
// ------------------------------
// AXI4 read channel field widths and encodings
// Data width fixes the largest legal ARSIZE
// Only OKAY and SLVERR are ever returned
// ------------------------------
package axi_rd_proto_pkg;

    // ------------------------------
    // Channel widths
    // ------------------------------

    // Byte address
    localparam int AXI_AW = 32;

    // Read data, one word per beat
    localparam int AXI_DW = 32;

    // Transaction ID
    localparam int AXI_IW = 4;

    // ARLEN holds beats minus one
    localparam int AXI_LEN_W = 8;

    // ARSIZE holds log2 of bytes per beat
    localparam int AXI_SIZE_W = 3;

    // ------------------------------
    // Encodings
    // ------------------------------

    // Burst type, 2'b11 is reserved
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } axi_burst_e;

    // Response per R beat
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

endpackage
